// ==== hdl/fetch_pkg.sv ====
// --------------------
// fetch stage types
// shared address, word and cache line types, plus the
// state encoding of the instruction cache FSM
// --------------------

package fetch_pkg;

    // byte address, used for pc, next pc and memory address
    typedef logic [63:0] addr_t;

    // one RISC-V instruction word
    typedef logic [31:0] instr_t;

    // half of a cache line, returned from the cache to the ifu
    typedef logic [63:0] half_t;

    // full cache line, one memory read beat
    typedef logic [127:0] line_t;

    // byte offset bits inside one 16-byte line
    localparam int OFFSET_W = 4;

    // cache FSM
    // IDLE    waits for a request and latches the address
    // LOOKUP  tag compare, ready on hit
    // REFILL  memory read in flight
    // FILL    writes the returned line into the arrays
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        FILL
    } cache_state_t;

endpackage

// ==== hdl/icache.sv ====
// --------------------
// direct-mapped instruction cache
// 128-bit lines, one valid bit per line, tag and data arrays
// a miss refills the whole line in one beat over a plain
// valid/ready read port
// rst acts as flush: valid bits clear, an in-flight refill finishes
// --------------------

module icache import fetch_pkg::*; #(
    parameter int NUM_LINES = 16
) (
    input  logic  clk,
    input  logic  rst,
    // lookup side
    input  addr_t addr_i,
    input  logic  req_i,
    output half_t data_o,
    output logic  ready_o,
    output logic  idle_o,
    // memory side
    output logic  mem_valid_o,
    output addr_t mem_addr_o,
    input  line_t mem_data_i,
    input  logic  mem_ready_i
);

    localparam int IDX_W = $clog2(NUM_LINES);
    localparam int TAG_W = 64 - OFFSET_W - IDX_W;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    cache_state_t state_q;
    cache_state_t state_d;

    addr_t addr_q;
    line_t line_q;
    logic  drop_q;

    logic [NUM_LINES-1:0] valid_q;
    tag_t  tag_mem [NUM_LINES];
    line_t data_mem [NUM_LINES];

    index_t idx;
    tag_t   tag;
    line_t  line_rd;
    logic   hit;

    // everything below works on the latched request address
    assign idx     = addr_q[OFFSET_W +: IDX_W];
    assign tag     = addr_q[63 -: TAG_W];
    assign line_rd = data_mem[idx];
    assign hit     = valid_q[idx] && (tag_mem[idx] == tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // no new lookup starts while a flush is active
                if (req_i && !rst) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ready_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                // compare again, the fresh line gives the hit
                state_d = LOOKUP;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // a flush lets a refill that has started run to its end,
    // an unknown state after power up falls back to IDLE
    always_ff @(posedge clk) begin
        state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i && !rst) begin
            addr_q <= addr_i;
        end
    end

    // remembers a flush seen while this line was on its way
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            drop_q <= rst;
        end else if (rst) begin
            drop_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == REFILL && mem_ready_i) begin
            line_q <= mem_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FILL) begin
            data_mem[idx] <= line_q;
            tag_mem[idx]  <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (state_q == FILL && !drop_q) begin
            valid_q[idx] <= 1'b1;
        end
    end

    assign ready_o     = (state_q == LOOKUP) && hit;
    assign idle_o      = (state_q == IDLE);
    assign mem_valid_o = (state_q == REFILL);
    assign mem_addr_o  = {addr_q[63:OFFSET_W], {OFFSET_W{1'b0}}};

    // address bit 3 picks the upper or lower 64 bits
    assign data_o = addr_q[3] ? line_rd[127:64] : line_rd[63:0];

    // refill request holds until memory answers
    a_mem_hold: assert property (
        @(posedge clk) mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o)
    );

    // ready is a single pulse outside IDLE, then the cache is free again
    a_ready_pulse: assert property (
        @(posedge clk) ready_o |-> (state_q != IDLE) ##1 (state_q == IDLE)
    );

endmodule

// ==== hdl/ifu.sv ====
// --------------------
// instruction fetch unit
// holds the pc, requests the half-line from the icache,
// selects the 32-bit word and keeps it until decode takes it
// --------------------

module ifu import fetch_pkg::*; #(
    parameter addr_t RESET_PC  = 64'h8000_0000,
    parameter int    NUM_LINES = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   fence_i_i,
    input  logic   dnpc_valid_i,
    input  logic   block_i,
    input  addr_t  dnpc_i,
    input  logic   id_en_i,
    output addr_t  pc_o,
    output instr_t instr_o,
    output logic   if_busy_o,
    // refill port
    output logic   mem_valid_o,
    output addr_t  mem_addr_o,
    input  line_t  mem_data_i,
    input  logic   mem_ready_i
);

    addr_t  pc_q;
    logic   start_q;
    logic   held_q;
    logic   doing_q;
    instr_t instr_q;

    logic   cache_req;
    logic   cache_ready;
    logic   cache_idle;
    logic   flush;
    half_t  cache_data;
    instr_t cache_word;
    logic   pc_en;

    assign pc_en = dnpc_valid_i && !block_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (pc_en) begin
            pc_q <= dnpc_i;
        end
    end

    // one-cycle pulse right after reset kicks off the first fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= 1'b1;
        end else begin
            start_q <= 1'b0;
        end
    end

    // a word has arrived and decode has not taken it yet
    always_ff @(posedge clk) begin
        if (rst || id_en_i) begin
            held_q <= 1'b0;
        end else if (cache_ready) begin
            held_q <= 1'b1;
        end
    end

    // lookup accepted by the cache, waiting for ready
    always_ff @(posedge clk) begin
        if (rst) begin
            doing_q <= 1'b0;
        end else if (cache_ready) begin
            doing_q <= 1'b0;
        end else if (cache_req && cache_idle) begin
            doing_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_ready) begin
            instr_q <= cache_word;
        end
    end

    assign cache_word = pc_q[2] ? cache_data[63:32] : cache_data[31:0];
    assign cache_req  = start_q || (!doing_q && !cache_ready && !held_q && !fence_i_i);
    assign flush      = rst || fence_i_i;

    assign pc_o      = pc_q;
    assign instr_o   = (id_en_i && held_q) ? instr_q : cache_word;
    assign if_busy_o = !cache_ready && !held_q && !fence_i_i;

    icache #(
        .NUM_LINES (NUM_LINES)
    ) icache0 (
        .clk         (clk),
        .rst         (flush),
        .addr_i      (pc_q),
        .req_i       (cache_req),
        .data_o      (cache_data),
        .ready_o     (cache_ready),
        .idle_o      (cache_idle),
        .mem_valid_o (mem_valid_o),
        .mem_addr_o  (mem_addr_o),
        .mem_data_i  (mem_data_i),
        .mem_ready_i (mem_ready_i)
    );

    // pc moves only on reset or an accepted next pc
    a_pc_hold: assert property (
        @(posedge clk) disable iff (rst) !pc_en |=> $stable(pc_q)
    );

endmodule

// ==== hdl/fetch_top.sv ====
// --------------------
// fetch stage top level
// sets the reset address and cache size, connects the
// ifu to decode and to the memory read port
// --------------------

module fetch_top import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fence_i_i,
    input  logic   dnpc_valid_i,
    input  logic   block_i,
    input  addr_t  dnpc_i,
    input  logic   id_en_i,
    output addr_t  pc_o,
    output instr_t instr_o,
    output logic   if_busy_o,
    // memory read port
    output logic   mem_valid_o,
    output addr_t  mem_addr_o,
    input  line_t  mem_data_i,
    input  logic   mem_ready_i
);

    localparam addr_t RESET_PC  = 64'h8000_0000;
    // must be a power of two
    localparam int    NUM_LINES = 16;

    ifu #(
        .RESET_PC  (RESET_PC),
        .NUM_LINES (NUM_LINES)
    ) ifu0 (
        .clk          (clk),
        .rst          (rst),
        .fence_i_i    (fence_i_i),
        .dnpc_valid_i (dnpc_valid_i),
        .block_i      (block_i),
        .dnpc_i       (dnpc_i),
        .id_en_i      (id_en_i),
        .pc_o         (pc_o),
        .instr_o      (instr_o),
        .if_busy_o    (if_busy_o),
        .mem_valid_o  (mem_valid_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_i   (mem_data_i),
        .mem_ready_i  (mem_ready_i)
    );

endmodule

// ==== dv/mem_model.sv ====
// --------------------
// memory responder for the refill port
// answers each read after 1 to 4 cycles with a computed
// 128-bit line and counts the refills it served
// --------------------

module mem_model import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_valid_i,
    input  addr_t mem_addr_i,
    output line_t mem_data_o,
    output logic  mem_ready_o,
    output int    refill_count_o
);

    integer seed;
    int     delay;

    // word at a byte address: low 32 bits of the word address xor a fixed pattern
    function automatic instr_t word_at(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'h1357_2468;
    endfunction

    // four words of the aligned line, lowest address in the lowest bits
    function automatic line_t line_at(input addr_t a);
        addr_t base;
        base = {a[63:4], 4'h0};
        return {word_at(base + 64'd12), word_at(base + 64'd8),
                word_at(base + 64'd4), word_at(base)};
    endfunction

    initial begin
        seed           = 32'hfb67;
        mem_data_o     = '0;
        mem_ready_o    = 1'b0;
        refill_count_o = 0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_valid_i && !rst) begin
                delay = 1 + $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_data_o     = line_at(mem_addr_i);
                mem_ready_o    = 1'b1;
                refill_count_o = refill_count_o + 1;
                @(posedge clk);
                #1;
                mem_ready_o = 1'b0;
            end
        end
    end

endmodule

// ==== dv/fetch_tb.sv ====
// --------------------
// fetch stage testbench
// runs a table of redirects, blocks, stalls and fence.i
// through the DUT and checks pc, word and refill count
// --------------------

module fetch_tb import fetch_pkg::*; ();

    localparam int    RESET_CYCLES = 16;
    localparam addr_t RESET_PC     = 64'h8000_0000;

    typedef struct packed {
        addr_t      dnpc;
        logic       dnpc_valid;
        logic       block;
        logic       fence;
        addr_t      exp_pc;
        logic       refill;
        logic [3:0] stall;
    } row_t;

    logic   clk = 1'b0;
    logic   rst;
    logic   fence_i;
    logic   dnpc_valid;
    logic   block;
    addr_t  dnpc;
    logic   id_en;
    addr_t  pc;
    instr_t instr;
    logic   if_busy;
    logic   mem_valid;
    addr_t  mem_addr;
    line_t  mem_data;
    logic   mem_ready;
    int     refills;

    row_t rows[$];
    int   cur_row = 0;
    int   exp_refills = 0;
    int   addr_errors = 0;
    int   instr_errors = 0;
    int   count_errors = 0;
    int   timeout_errors = 0;
    int   cycle_count = 0;
    int   timeout_limit;

    always #5 clk = ~clk;

    fetch_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .fence_i_i    (fence_i),
        .dnpc_valid_i (dnpc_valid),
        .block_i      (block),
        .dnpc_i       (dnpc),
        .id_en_i      (id_en),
        .pc_o         (pc),
        .instr_o      (instr),
        .if_busy_o    (if_busy),
        .mem_valid_o  (mem_valid),
        .mem_addr_o   (mem_addr),
        .mem_data_i   (mem_data),
        .mem_ready_i  (mem_ready)
    );

    mem_model mem0 (
        .clk            (clk),
        .rst            (rst),
        .mem_valid_i    (mem_valid),
        .mem_addr_i     (mem_addr),
        .mem_data_o     (mem_data),
        .mem_ready_o    (mem_ready),
        .refill_count_o (refills)
    );

    // expected word for a pc
    function automatic instr_t expected_word(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'h1357_2468;
    endfunction

    task automatic check_addr(input addr_t got, input addr_t exp, input int row,
                              input string name);
        if (got !== exp) begin
            addr_errors++;
            $display("Error at %0t: row %0d %s is %h, expected %h",
                     $time, row, name, got, exp);
        end
    endtask

    task automatic check_instr(input instr_t got, input instr_t exp, input int row);
        if (got !== exp) begin
            instr_errors++;
            $display("Error at %0t: row %0d instr_o is %h, expected %h", $time, row, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input int row);
        if (got != exp) begin
            count_errors++;
            $display("Error at %0t: row %0d refill count is %0d, expected %0d",
                     $time, row, got, exp);
        end
    endtask

    task automatic add_row(input addr_t new_pc, input logic valid, input logic blk,
                           input logic fence, input addr_t exp_pc, input logic refill,
                           input int stall);
        row_t r;
        r.dnpc       = new_pc;
        r.dnpc_valid = valid;
        r.block      = blk;
        r.fence      = fence;
        r.exp_pc     = exp_pc;
        r.refill     = refill;
        r.stall      = stall[3:0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        // dnpc, dnpc valid, block, fence.i, expected pc, new refill, stall cycles
        // first fetch at the reset address
        add_row(64'h0, 1'b0, 1'b0, 1'b0, RESET_PC, 1'b1, 0);
        // sequential words in both halves of the line, then the next line
        add_row(64'h8000_0004, 1'b1, 1'b0, 1'b0, 64'h8000_0004, 1'b0, 0);
        add_row(64'h8000_0008, 1'b1, 1'b0, 1'b0, 64'h8000_0008, 1'b0, 0);
        add_row(64'h8000_000c, 1'b1, 1'b0, 1'b0, 64'h8000_000c, 1'b0, 0);
        add_row(64'h8000_0010, 1'b1, 1'b0, 1'b0, 64'h8000_0010, 1'b1, 0);
        add_row(64'h8000_0014, 1'b1, 1'b0, 1'b0, 64'h8000_0014, 1'b0, 0);
        // far redirect, then back to a line that is still cached
        add_row(64'h8000_1230, 1'b1, 1'b0, 1'b0, 64'h8000_1230, 1'b1, 0);
        add_row(64'h8000_1234, 1'b1, 1'b0, 1'b0, 64'h8000_1234, 1'b0, 0);
        add_row(64'h8000_0008, 1'b1, 1'b0, 1'b0, 64'h8000_0008, 1'b0, 0);
        // index 0 conflict evicts the first line
        add_row(64'h8000_2000, 1'b1, 1'b0, 1'b0, 64'h8000_2000, 1'b1, 0);
        add_row(64'h8000_0004, 1'b1, 1'b0, 1'b0, 64'h8000_0004, 1'b1, 0);
        // blocked redirects
        add_row(64'h9000_0000, 1'b1, 1'b1, 1'b0, 64'h8000_0004, 1'b0, 0);
        add_row(64'h8000_1230, 1'b1, 1'b1, 1'b0, 64'h8000_0004, 1'b0, 0);
        // decode holds off on a hit and on a miss
        add_row(64'h8000_0018, 1'b1, 1'b0, 1'b0, 64'h8000_0018, 1'b0, 6);
        add_row(64'h8000_3040, 1'b1, 1'b0, 1'b0, 64'h8000_3040, 1'b1, 5);
        // fence.i drops every cached line
        add_row(64'h8000_1238, 1'b1, 1'b0, 1'b1, 64'h8000_1238, 1'b1, 0);
        add_row(64'h8000_0010, 1'b1, 1'b0, 1'b0, 64'h8000_0010, 1'b1, 0);
        add_row(64'h0, 1'b0, 1'b0, 1'b1, 64'h8000_0010, 1'b1, 0);
        add_row(64'h8000_001c, 1'b1, 1'b0, 1'b0, 64'h8000_001c, 1'b0, 3);
    endtask

    // decode takes the previous word in the same cycle that the row is applied,
    // so the next request already sees the new pc
    task automatic run_row(input int n);
        row_t r;
        r          = rows[n];
        cur_row    = n;
        id_en      = (n > 0);
        dnpc       = r.dnpc;
        dnpc_valid = r.dnpc_valid;
        block      = r.block;
        fence_i    = r.fence;
        @(negedge clk);
        if (n > 0) begin
            // decode sees the held word of the previous row
            check_instr(instr, expected_word(rows[n-1].exp_pc), n);
        end
        @(posedge clk);
        #1;
        id_en      = 1'b0;
        dnpc_valid = 1'b0;
        block      = 1'b0;
        fence_i    = 1'b0;
        @(negedge clk);
        while (if_busy) begin
            @(negedge clk);
        end
        if (r.refill) begin
            exp_refills++;
        end
        check_addr(pc, r.exp_pc, n, "pc_o");
        check_instr(instr, expected_word(r.exp_pc), n);
        check_count(refills, exp_refills, n);
        // word must stay put while decode is stalled
        repeat (r.stall) begin
            @(negedge clk);
            check_addr(pc, r.exp_pc, n, "pc_o");
            check_instr(instr, expected_word(r.exp_pc), n);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_and_finish();
        int total;
        total = addr_errors + instr_errors + count_errors + timeout_errors;
        $display("errors: %0d (address %0d, instr %0d, refill count %0d, timeout %0d)",
                 total, addr_errors, instr_errors, count_errors, timeout_errors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // a refill reads the aligned line of the pc under fetch
    always @(negedge clk) begin
        if (mem_valid === 1'b1) begin
            check_addr(mem_addr, {rows[cur_row].exp_pc[63:4], 4'h0}, cur_row, "mem_addr_o");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_limit) begin
            timeout_errors = 1;
            $display("timeout: the DUT did not deliver a word within %0d cycles", timeout_limit);
            report_and_finish();
        end
    end

    initial begin
        rst        = 1'b1;
        fence_i    = 1'b0;
        dnpc_valid = 1'b0;
        block      = 1'b0;
        dnpc       = '0;
        id_en      = 1'b0;
        build_table();
        timeout_limit = 60 * rows.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        // hand the last word to decode
        id_en = 1'b1;
        @(negedge clk);
        check_instr(instr, expected_word(rows[rows.size()-1].exp_pc), rows.size());
        @(posedge clk);
        #1;
        id_en = 1'b0;
        report_and_finish();
    end

endmodule

// ==== compile.f ====
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/ifu.sv
hdl/fetch_top.sv
dv/mem_model.sv
dv/fetch_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module fetch_tb -f compile.f \
		-Mdir obj_dir -o Vfetch_tb

run: compile
	@out="$$(./obj_dir/Vfetch_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
